// ==== Makefile ====
# Verilator build and run of the trace bridge testbench

TOP := rvvi_trace_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --assert --top-module $(TOP) -f filelist.f
	./obj_dir/V$(TOP) +verilator+error+limit+100 | \
		awk '{ print } /^No errors$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

// ==== filelist.f ====
logic/rvvi_trace_pkg.sv
logic/retire_trace_stage.sv
logic/csr_trace_merge.sv
logic/debug_halt_stretch.sv
logic/nmi_cause_tracker.sv
logic/irq_change_detect.sv
logic/rvvi_trace_top.sv
verification/rvvi_trace_properties.sv
verification/rvvi_trace_tb.sv

// ==== logic/csr_trace_merge.sv ====
// CSR merge stage of the trace bridge
// Folds each CSR read/write record into one value and flags write-backs
`default_nettype none

module csr_trace_merge (
   input  wire logic                        rvvi,
   input  wire logic                        rst_n_i,
   input  wire rvvi_trace_pkg::csr_rec_t    csr_rec_i [rvvi_trace_pkg::NUM_CSR],
   input  wire logic                        retire_i,
   output logic [rvvi_trace_pkg::XLEN-1:0]  csr_o     [rvvi_trace_pkg::NUM_CSR],
   output logic [rvvi_trace_pkg::NUM_CSR-1:0] csr_wb_o
);
   import rvvi_trace_pkg::*;

   logic [XLEN-1:0]    merged [NUM_CSR];
   logic [NUM_CSR-1:0] changed;

   ////////////////////////////////////////////////////////////
   // Merge and compare

   always_comb begin
      for (int k = 0; k < NUM_CSR; k++) begin
         // Written bits win
         // Read bits only count outside wmask and inside rmask
         merged[k] = (csr_rec_i[k].wdata & csr_rec_i[k].wmask)
                   | (csr_rec_i[k].rdata & ~csr_rec_i[k].wmask & csr_rec_i[k].rmask);
         // Against what went out last cycle
         changed[k] = (merged[k] != csr_o[k]);
      end
   end

   ////////////////////////////////////////////////////////////
   // Value and write-back flag

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         for (int k = 0; k < NUM_CSR; k++) begin
            csr_o[k] <= '0;
         end
         csr_wb_o <= '0;
      end else begin
         for (int k = 0; k < NUM_CSR; k++) begin
            csr_o[k] <= merged[k];
            // Sticky until a retirement consumes it
            // A change in the same cycle keeps it set
            if (changed[k]) begin
               csr_wb_o[k] <= 1'b1;
            end else if (retire_i) begin
               csr_wb_o[k] <= 1'b0;
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/debug_halt_stretch.sv ====
// Halt request stretcher
// Keeps haltreq up for HALT_HOLD cycles after the debug request drops
`default_nettype none

module debug_halt_stretch #(
   parameter int HALT_HOLD = 5
) (
   input  wire logic rvvi,
   input  wire logic rst_n_i,
   input  wire logic debug_req_i,
   output logic      haltreq_o
);

   localparam int CNT_W = $clog2(HALT_HOLD + 1);

   logic [CNT_W-1:0] cnt_q;
   logic [CNT_W-1:0] cnt_d;

   // Reload on every request cycle, else run down to zero
   always_comb begin
      if (debug_req_i) begin
         cnt_d = CNT_W'(HALT_HOLD);
      end else if (cnt_q != '0) begin
         cnt_d = cnt_q - CNT_W'(1);
      end else begin
         cnt_d = '0;
      end
   end

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         cnt_q     <= '0;
         haltreq_o <= 1'b0;
      end else begin
         cnt_q     <= cnt_d;
         // Same as cnt_q != 0, one flop closer to the port
         haltreq_o <= (cnt_d != '0);
      end
   end

endmodule

`default_nettype wire

// ==== logic/irq_change_detect.sv ====
// Interrupt view of the trace bridge
// Splits irq_i into named lines and pulses once per change of the vector
`default_nettype none

module irq_change_detect (
   input  wire logic                        rvvi,
   input  wire logic                        rst_n_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0] irq_i,
   output rvvi_trace_pkg::irq_lines_t       irq_lines_o,
   output logic                             irq_update_o
);
   import rvvi_trace_pkg::*;

   // Last sampled vector, all 32 bits
   logic [XLEN-1:0] irq_q;

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         irq_q        <= '0;
         irq_update_o <= 1'b0;
      end else begin
         irq_q        <= irq_i;
         // Unmapped bits count as a change too
         irq_update_o <= (irq_i != irq_q);
      end
   end

   ////////////////////////////////////////////////////////////
   // Named lines, plain wiring from the register

   assign irq_lines_o.msw       = irq_q[3];
   assign irq_lines_o.mtimer    = irq_q[7];
   assign irq_lines_o.mext      = irq_q[11];
   assign irq_lines_o.local_irq = irq_q[31:16];

endmodule

`default_nettype wire

// ==== logic/nmi_cause_tracker.sv ====
// NMI source for load/store bus errors
// Tracks data request direction so the cause names the oldest access
`default_nettype none

module nmi_cause_tracker #(
   parameter int LDST_DEPTH = 4
) (
   input  wire logic                      rvvi,
   input  wire logic                      rst_n_i,
   input  wire logic                      data_req_i,
   input  wire logic                      data_we_i,
   input  wire logic                      retire_i,
   input  wire logic                      data_rvalid_i,
   input  wire logic                      data_err_i,
   output logic                           nmi_o,
   output logic [rvvi_trace_pkg::XLEN-1:0] nmi_cause_o
);
   import rvvi_trace_pkg::*;

   localparam int PTR_W = (LDST_DEPTH > 1) ? $clog2(LDST_DEPTH) : 1;
   localparam int CNT_W = $clog2(LDST_DEPTH + 1);

   ////////////////////////////////////////////////////////////
   // Direction queue

   // 1 = store, 0 = load
   logic             ldst_mem [LDST_DEPTH];
   logic [PTR_W-1:0] wr_ptr;
   logic [PTR_W-1:0] rd_ptr;
   logic [CNT_W-1:0] count;
   logic             push;
   logic             pop;

   // Full and empty judged on the count at the start of the cycle
   assign push = data_req_i && (count != CNT_W'(LDST_DEPTH));
   assign pop  = retire_i && (count != '0);

   // Direction of each pushed request, all loads after reset
   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         for (int i = 0; i < LDST_DEPTH; i++) begin
            ldst_mem[i] <= 1'b0;
         end
      end else if (push) begin
         ldst_mem[wr_ptr] <= data_we_i;
      end
   end

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end else begin
         // Wrap by compare, depth need not be a power of two
         if (push) begin
            wr_ptr <= (wr_ptr == PTR_W'(LDST_DEPTH - 1)) ? '0 : wr_ptr + PTR_W'(1);
         end
         if (pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(LDST_DEPTH - 1)) ? '0 : rd_ptr + PTR_W'(1);
         end
         case ({push, pop})
            2'b10:   count <= count + CNT_W'(1);
            2'b01:   count <= count - CNT_W'(1);
            default: count <= count;
         endcase
      end
   end

   ////////////////////////////////////////////////////////////
   // Cause and NMI

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         nmi_cause_o <= NMI_CAUSE_LOAD;
         nmi_o       <= 1'b0;
      end else begin
         // Empty pop keeps the last cause
         if (pop) begin
            nmi_cause_o <= ldst_mem[rd_ptr] ? NMI_CAUSE_STORE : NMI_CAUSE_LOAD;
         end
         // Error only counts on a valid response
         nmi_o <= data_err_i && data_rvalid_i;
      end
   end

endmodule

`default_nettype wire

// ==== logic/retire_trace_stage.sv ====
// Retired-instruction stage of the trace bridge
// Registers the core's retirement record and decodes the GPR write-back
`default_nettype none

module retire_trace_stage (
   input  wire logic                       rvvi,
   input  wire logic                       rst_n_i,
   input  wire rvvi_trace_pkg::rvfi_instr_t rvfi_i,
   output rvvi_trace_pkg::rvvi_instr_t     trace_o
);
   import rvvi_trace_pkg::*;

   ////////////////////////////////////////////////////////////
   // GPR write-back decode

   logic [XLEN-1:0] x_wb_d;
   logic [XLEN-1:0] x_wdata_d;

   always_comb begin
      // One-hot on rd, x0 keeps its bit in the mask
      x_wb_d = '0;
      x_wb_d[rvfi_i.rd_addr] = 1'b1;
      // Writes to x0 carry no data
      if (rvfi_i.rd_addr != 5'd0) begin
         x_wdata_d = rvfi_i.rd_wdata;
      end else begin
         x_wdata_d = '0;
      end
   end

   ////////////////////////////////////////////////////////////
   // Trace register

   always_ff @(posedge rvvi) begin
      if (!rst_n_i) begin
         trace_o <= '0;
      end else begin
         // Straight copy of the instruction fields
         trace_o.valid    <= rvfi_i.valid;
         trace_o.order    <= rvfi_i.order;
         trace_o.insn     <= rvfi_i.insn;
         trace_o.trap     <= rvfi_i.trap;
         trace_o.intr     <= rvfi_i.intr;
         trace_o.mode     <= rvfi_i.mode;
         trace_o.ixl      <= rvfi_i.ixl;
         trace_o.pc_rdata <= rvfi_i.pc_rdata;
         trace_o.pc_wdata <= rvfi_i.pc_wdata;
         // Decoded write-back
         trace_o.x_wb     <= x_wb_d;
         trace_o.x_wdata  <= x_wdata_d;
      end
   end

endmodule

`default_nettype wire

// ==== logic/rvvi_trace_pkg.sv ====
// Shared records, CSR index list and NMI cause codes for the trace bridge
// Blocks pull these in with a wildcard import where the body needs them
`default_nettype none

package rvvi_trace_pkg;

   // Data width of the traced hart
   localparam int XLEN = 32;

   ////////////////////////////////////////////////////////////
   // Instruction records

   // One retired instruction as the core reports it
   typedef struct packed {
      logic            valid;
      logic [63:0]     order;
      logic [XLEN-1:0] insn;
      logic            trap;
      logic            intr;
      logic [1:0]      mode;
      logic [1:0]      ixl;
      logic [XLEN-1:0] pc_rdata;
      logic [XLEN-1:0] pc_wdata;
      logic [4:0]      rd_addr;
      logic [XLEN-1:0] rd_wdata;
   } rvfi_instr_t;

   // Registered trace record, GPR write-back already decoded
   typedef struct packed {
      logic            valid;
      logic [63:0]     order;
      logic [XLEN-1:0] insn;
      logic            trap;
      logic            intr;
      logic [1:0]      mode;
      logic [1:0]      ixl;
      logic [XLEN-1:0] pc_rdata;
      logic [XLEN-1:0] pc_wdata;
      logic [XLEN-1:0] x_wb;
      logic [XLEN-1:0] x_wdata;
   } rvvi_instr_t;

   ////////////////////////////////////////////////////////////
   // CSR records

   // Read and write halves of one CSR access
   typedef struct packed {
      logic [XLEN-1:0] rdata;
      logic [XLEN-1:0] rmask;
      logic [XLEN-1:0] wdata;
      logic [XLEN-1:0] wmask;
   } csr_rec_t;

   // Traced CSRs, position is the array index
   typedef enum int unsigned {
      CSR_MSTATUS,
      CSR_MISA,
      CSR_MIE,
      CSR_MTVEC,
      CSR_MSCRATCH,
      CSR_MEPC,
      CSR_MCAUSE,
      CSR_MTVAL,
      CSR_MIP,
      CSR_MCYCLE,
      CSR_MINSTRET
   } csr_idx_e;

   localparam int NUM_CSR = int'(CSR_MINSTRET) + 1;

   ////////////////////////////////////////////////////////////
   // Interrupts

   // Named machine interrupt lines, local_irq[0] is irq bit 16
   typedef struct packed {
      logic [15:0] local_irq;
      logic        mext;
      logic        mtimer;
      logic        msw;
   } irq_lines_t;

   // NMI cause for a bus error on a load or a store
   localparam logic [XLEN-1:0] NMI_CAUSE_LOAD  = 32'd1024;
   localparam logic [XLEN-1:0] NMI_CAUSE_STORE = 32'd1025;

endpackage

`default_nettype wire

// ==== logic/rvvi_trace_top.sv ====
// Top of the retirement trace bridge
// Wires the five trace blocks together, every path is one cycle
`default_nettype none

module rvvi_trace_top #(
   parameter int HALT_HOLD  = 5,
   parameter int LDST_DEPTH = 4
) (
   input  wire logic                          rvvi,
   input  wire logic                          rst_n_i,
   input  wire rvvi_trace_pkg::rvfi_instr_t   rvfi_i,
   input  wire rvvi_trace_pkg::csr_rec_t      csr_rec_i [rvvi_trace_pkg::NUM_CSR],
   input  wire logic                          debug_req_i,
   input  wire logic                          data_req_i,
   input  wire logic                          data_we_i,
   input  wire logic                          data_rvalid_i,
   input  wire logic                          data_err_i,
   input  wire logic [rvvi_trace_pkg::XLEN-1:0] irq_i,
   output rvvi_trace_pkg::rvvi_instr_t        trace_o,
   output logic [rvvi_trace_pkg::XLEN-1:0]    csr_o [rvvi_trace_pkg::NUM_CSR],
   output logic [rvvi_trace_pkg::NUM_CSR-1:0] csr_wb_o,
   output logic                               haltreq_o,
   output logic                               nmi_o,
   output logic [rvvi_trace_pkg::XLEN-1:0]    nmi_cause_o,
   output rvvi_trace_pkg::irq_lines_t         irq_lines_o,
   output logic                               irq_update_o
);

   ////////////////////////////////////////////////////////////
   // Instruction and CSR trace

   retire_trace_stage u_retire (
      .rvvi    (rvvi),
      .rst_n_i (rst_n_i),
      .rvfi_i  (rvfi_i),
      .trace_o (trace_o)
   );

   // Retirement clears the CSR write-back flags
   csr_trace_merge u_csr (
      .rvvi      (rvvi),
      .rst_n_i   (rst_n_i),
      .csr_rec_i (csr_rec_i),
      .retire_i  (rvfi_i.valid),
      .csr_o     (csr_o),
      .csr_wb_o  (csr_wb_o)
   );

   ////////////////////////////////////////////////////////////
   // Halt, NMI and interrupt side channels

   debug_halt_stretch #(
      .HALT_HOLD (HALT_HOLD)
   ) u_halt (
      .rvvi        (rvvi),
      .rst_n_i     (rst_n_i),
      .debug_req_i (debug_req_i),
      .haltreq_o   (haltreq_o)
   );

   // Retirement pops the load/store queue
   nmi_cause_tracker #(
      .LDST_DEPTH (LDST_DEPTH)
   ) u_nmi (
      .rvvi          (rvvi),
      .rst_n_i       (rst_n_i),
      .data_req_i    (data_req_i),
      .data_we_i     (data_we_i),
      .retire_i      (rvfi_i.valid),
      .data_rvalid_i (data_rvalid_i),
      .data_err_i    (data_err_i),
      .nmi_o         (nmi_o),
      .nmi_cause_o   (nmi_cause_o)
   );

   irq_change_detect u_irq (
      .rvvi         (rvvi),
      .rst_n_i      (rst_n_i),
      .irq_i        (irq_i),
      .irq_lines_o  (irq_lines_o),
      .irq_update_o (irq_update_o)
   );

endmodule

`default_nettype wire

// ==== verification/rvvi_trace_properties.sv ====
// Concurrent checks on the trace bridge outputs, bound into the top level
// Covers reset values, the GPR write-back mask shape and the IRQ change pulse
`default_nettype none

module rvvi_trace_properties (
   input wire logic                               rvvi,
   input wire logic                               rst_n_i,
   input wire rvvi_trace_pkg::rvvi_instr_t        trace_i,
   input wire logic [rvvi_trace_pkg::NUM_CSR-1:0] csr_wb_i,
   input wire logic                               haltreq_i,
   input wire logic                               nmi_i,
   input wire logic [rvvi_trace_pkg::XLEN-1:0]    nmi_cause_i,
   input wire logic [rvvi_trace_pkg::XLEN-1:0]    irq_i,
   input wire logic                               irq_update_i
);
   import rvvi_trace_pkg::*;

   ////////////////////////////////////////////////////////////
   // Reset

   // Cycle after a reset sample, all flags low and cause back to load
   reset_values: assert property (@(posedge rvvi)
      !rst_n_i |=> (!trace_i.valid && (csr_wb_i == '0) && !haltreq_i && !nmi_i
                    && (nmi_cause_i == NMI_CAUSE_LOAD) && !irq_update_i))
      else $error("outputs not at their reset values after reset");

   ////////////////////////////////////////////////////////////
   // Write-back mask and interrupt pulse

   // Any non-reset cycle yields exactly one bit in x_wb
   x_wb_onehot: assert property (@(posedge rvvi)
      rst_n_i |=> $onehot(trace_i.x_wb))
      else $error("x_wb is not one-hot");

   // Change of the full vector gives the pulse
   irq_pulse_on_change: assert property (@(posedge rvvi)
      (rst_n_i && $past(rst_n_i) && (irq_i != $past(irq_i))) |=> irq_update_i)
      else $error("irq_update_o missing after an irq change");

   // Stable vector keeps it low
   irq_quiet_when_stable: assert property (@(posedge rvvi)
      (rst_n_i && $past(rst_n_i) && (irq_i == $past(irq_i))) |=> !irq_update_i)
      else $error("irq_update_o high without an irq change");

endmodule

bind rvvi_trace_top rvvi_trace_properties u_props (
   .rvvi         (rvvi),
   .rst_n_i      (rst_n_i),
   .trace_i      (trace_o),
   .csr_wb_i     (csr_wb_o),
   .haltreq_i    (haltreq_o),
   .nmi_i        (nmi_o),
   .nmi_cause_i  (nmi_cause_o),
   .irq_i        (irq_i),
   .irq_update_i (irq_update_o)
);

`default_nettype wire

// ==== verification/rvvi_trace_tb.sv ====
// Testbench of the retirement trace bridge
// Random stimulus from an LCG, reference models per block, checks on every negedge
`default_nettype none

module rvvi_trace_tb;
   import rvvi_trace_pkg::*;

   localparam int HALT_HOLD      = 5;
   localparam int LDST_DEPTH     = 4;
   // Stimulus length, timeout leaves margin above it
   localparam int NUM_CYCLES     = 1200;
   localparam int TIMEOUT_CYCLES = 2000;

   logic            rvvi = 1'b0;
   logic            rst_n_i;
   rvfi_instr_t     rvfi_i;
   csr_rec_t        csr_rec_i [NUM_CSR];
   logic            debug_req_i;
   logic            data_req_i;
   logic            data_we_i;
   logic            data_rvalid_i;
   logic            data_err_i;
   logic [XLEN-1:0] irq_i;

   rvvi_instr_t        trace_o;
   logic [XLEN-1:0]    csr_o [NUM_CSR];
   logic [NUM_CSR-1:0] csr_wb_o;
   logic               haltreq_o;
   logic               nmi_o;
   logic [XLEN-1:0]    nmi_cause_o;
   irq_lines_t         irq_lines_o;
   logic               irq_update_o;

   // Expected state, one model per block
   rvvi_instr_t        exp_trace;
   logic [XLEN-1:0]    exp_csr [NUM_CSR];
   logic [NUM_CSR-1:0] exp_wb;
   int                 halt_cnt;
   logic               exp_halt;
   logic               ldst_q [$];
   logic [XLEN-1:0]    exp_cause;
   logic               exp_nmi;
   logic [XLEN-1:0]    irq_last;
   irq_lines_t         exp_lines;
   logic               exp_update;

   logic [31:0] rng;
   int          cycle_cnt = 0;

   rvvi_trace_top u_dut (
      .rvvi          (rvvi),
      .rst_n_i       (rst_n_i),
      .rvfi_i        (rvfi_i),
      .csr_rec_i     (csr_rec_i),
      .debug_req_i   (debug_req_i),
      .data_req_i    (data_req_i),
      .data_we_i     (data_we_i),
      .data_rvalid_i (data_rvalid_i),
      .data_err_i    (data_err_i),
      .irq_i         (irq_i),
      .trace_o       (trace_o),
      .csr_o         (csr_o),
      .csr_wb_o      (csr_wb_o),
      .haltreq_o     (haltreq_o),
      .nmi_o         (nmi_o),
      .nmi_cause_o   (nmi_cause_o),
      .irq_lines_o   (irq_lines_o),
      .irq_update_o  (irq_update_o)
   );

   always #50 rvvi = ~rvvi;

   ////////////////////////////////////////////////////////////
   // Helpers

   // Two LCG steps, upper halves only since low bits cycle fast
   function automatic logic [31:0] next_rand();
      logic [31:0] hi;
      rng = rng * 32'd1103515245 + 32'd12345;
      hi  = rng;
      rng = rng * 32'd1103515245 + 32'd12345;
      return {hi[31:16], rng[31:16]};
   endfunction

   // Bit by bit: write mask first, then read mask, else zero
   function automatic logic [XLEN-1:0] csr_view(input csr_rec_t rec);
      logic [XLEN-1:0] v;
      for (int b = 0; b < XLEN; b++) begin
         if (rec.wmask[b]) begin
            v[b] = rec.wdata[b];
         end else if (rec.rmask[b]) begin
            v[b] = rec.rdata[b];
         end else begin
            v[b] = 1'b0;
         end
      end
      return v;
   endfunction

   task automatic check_value(input string name, input logic [255:0] expected,
                              input logic [255:0] actual);
      assert (actual === expected) else begin
         $display("[ERROR] t=%0t %s expected %0h actual %0h", $time, name, expected, actual);
         $display("Errors found");
         $fatal(1, "value mismatch on %s", name);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Models, advanced on each rising edge from the sampled inputs

   task automatic update_models();
      logic [XLEN-1:0] merged;
      int              start_size;
      logic            popped;
      if (!rst_n_i) begin
         exp_trace = '0;
         for (int k = 0; k < NUM_CSR; k++) begin
            exp_csr[k] = '0;
         end
         exp_wb     = '0;
         halt_cnt   = 0;
         exp_halt   = 1'b0;
         ldst_q.delete();
         exp_cause  = NMI_CAUSE_LOAD;
         exp_nmi    = 1'b0;
         irq_last   = '0;
         exp_lines  = '0;
         exp_update = 1'b0;
      end else begin
         // Instruction fields copied, write-back as a shifted one
         exp_trace.valid    = rvfi_i.valid;
         exp_trace.order    = rvfi_i.order;
         exp_trace.insn     = rvfi_i.insn;
         exp_trace.trap     = rvfi_i.trap;
         exp_trace.intr     = rvfi_i.intr;
         exp_trace.mode     = rvfi_i.mode;
         exp_trace.ixl      = rvfi_i.ixl;
         exp_trace.pc_rdata = rvfi_i.pc_rdata;
         exp_trace.pc_wdata = rvfi_i.pc_wdata;
         exp_trace.x_wb     = 32'd1 << rvfi_i.rd_addr;
         exp_trace.x_wdata  = (rvfi_i.rd_addr == 5'd0) ? '0 : rvfi_i.rd_wdata;
         // CSR flag: change sets, retire without change clears
         for (int k = 0; k < NUM_CSR; k++) begin
            merged = csr_view(csr_rec_i[k]);
            if (merged != exp_csr[k]) begin
               exp_wb[k] = 1'b1;
            end else if (rvfi_i.valid) begin
               exp_wb[k] = 1'b0;
            end
            exp_csr[k] = merged;
         end
         // Halt hold counter
         if (debug_req_i) begin
            halt_cnt = HALT_HOLD;
         end else if (halt_cnt > 0) begin
            halt_cnt = halt_cnt - 1;
         end
         exp_halt = (halt_cnt != 0);
         // Full and empty taken before this cycle's push and pop
         start_size = ldst_q.size();
         if (rvfi_i.valid && start_size > 0) begin
            popped    = ldst_q.pop_front();
            exp_cause = popped ? NMI_CAUSE_STORE : NMI_CAUSE_LOAD;
         end
         if (data_req_i && start_size < LDST_DEPTH) begin
            ldst_q.push_back(data_we_i);
         end
         exp_nmi = data_err_i && data_rvalid_i;
         // Interrupt lines and change pulse
         exp_lines.msw       = irq_i[3];
         exp_lines.mtimer    = irq_i[7];
         exp_lines.mext      = irq_i[11];
         exp_lines.local_irq = irq_i[31:16];
         exp_update          = (irq_i != irq_last);
         irq_last            = irq_i;
      end
   endtask

   task automatic check_outputs();
      check_value("trace_o", 256'(exp_trace), 256'(trace_o));
      for (int k = 0; k < NUM_CSR; k++) begin
         check_value($sformatf("csr_o[%0d]", k), 256'(exp_csr[k]), 256'(csr_o[k]));
      end
      check_value("csr_wb_o", 256'(exp_wb), 256'(csr_wb_o));
      check_value("haltreq_o", 256'(exp_halt), 256'(haltreq_o));
      check_value("nmi_o", 256'(exp_nmi), 256'(nmi_o));
      check_value("nmi_cause_o", 256'(exp_cause), 256'(nmi_cause_o));
      check_value("irq_lines_o", 256'(exp_lines), 256'(irq_lines_o));
      check_value("irq_update_o", 256'(exp_update), 256'(irq_update_o));
   endtask

   ////////////////////////////////////////////////////////////
   // Stimulus

   task automatic drive_inputs(input int c);
      logic [31:0] r_a;
      logic [31:0] r_b;
      logic [31:0] r_c;
      int          req_thr;
      int          ret_thr;
      int          dbg_thr;
      r_a = next_rand();
      r_b = next_rand();
      // Fill phase, drain phase, then balanced
      req_thr = (c < 300) ? 192 : ((c < 500) ? 64 : 128);
      ret_thr = (c < 300) ? 64 : ((c < 500) ? 192 : 128);
      // Long debug bursts for a while, sparse pulses elsewhere
      dbg_thr = (c >= 800 && c < 900) ? 160 : 24;
      // Reset at the start and once mid-run
      rst_n_i <= !(c < 2 || (c >= 600 && c < 603));
      rvfi_i.valid    <= (int'(r_a[7:0]) < ret_thr);
      rvfi_i.order    <= {next_rand(), next_rand()};
      rvfi_i.insn     <= next_rand();
      rvfi_i.trap     <= r_a[8];
      rvfi_i.intr     <= r_a[9];
      rvfi_i.mode     <= r_a[11:10];
      rvfi_i.ixl      <= r_a[13:12];
      rvfi_i.pc_rdata <= next_rand();
      rvfi_i.pc_wdata <= next_rand();
      rvfi_i.rd_addr  <= r_a[20:16];
      rvfi_i.rd_wdata <= next_rand();
      data_req_i    <= (int'(r_b[7:0]) < req_thr);
      data_we_i     <= r_b[8];
      data_rvalid_i <= r_b[9];
      data_err_i    <= r_b[10] & r_b[11];
      debug_req_i   <= (int'(r_b[23:16]) < dbg_thr);
      // Single bit flips, mapped or not
      if (r_b[13:12] == 2'd0) begin
         irq_i <= irq_i ^ (32'd1 << r_b[28:24]);
      end
      // Records mostly held so the clear path is reached
      for (int k = 0; k < NUM_CSR; k++) begin
         r_c = next_rand();
         if (r_c[1:0] == 2'd0) begin
            csr_rec_i[k] <= {next_rand(), next_rand(), next_rand(), next_rand()};
         end
      end
   endtask

   initial begin
      rng           = 32'he258;
      rst_n_i       = 1'b0;
      rvfi_i        = '0;
      debug_req_i   = 1'b0;
      data_req_i    = 1'b0;
      data_we_i     = 1'b0;
      data_rvalid_i = 1'b0;
      data_err_i    = 1'b0;
      irq_i         = '0;
      for (int k = 0; k < NUM_CSR; k++) begin
         csr_rec_i[k] = '0;
      end
      // Model and drive on the rising edge, check on the falling one
      for (int c = 0; c < NUM_CYCLES; c++) begin
         @(posedge rvvi);
         update_models();
         drive_inputs(c);
         @(negedge rvvi);
         check_outputs();
      end
      $display("No errors");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Watchdog

   always @(posedge rvvi) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
         $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
         $display("Errors found");
         $fatal(1, "watchdog expired");
      end
   end

endmodule

`default_nettype wire
